//--- all.f
src/mc_cpu_pkg.sv
src/alu.sv
src/regfile.sv
src/cpu_ctrl.sv
src/inst_decode.sv
src/pc_unit.sv
src/exec_stage.sv
src/mc_cpu_top.sv
sim/sram_model.sv
sim/cpu_tb.sv

//--- sim/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import mc_cpu_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;
    localparam int RESET_CYCLES   = 16;
    localparam int DRAIN_CYCLES   = 6;    // longest instruction is five cycles.
    localparam int FIRST_WB_CYCLE = 4;
    localparam int NUM_TESTS      = 6;
    localparam int INSTR_COUNT    = 73;   // executed instructions over all tests, halts included.
    localparam int TIMEOUT_CYCLES = 5 * INSTR_COUNT + RESET_CYCLES * NUM_TESTS + 200;

    localparam logic [9:0] OP_ADDI = 10'h00a;
    localparam logic [9:0] OP_LD   = 10'h0a2;
    localparam logic [9:0] OP_ST   = 10'h0a6;
    localparam logic [5:0] OP_JIRL = 6'h13;
    localparam logic [5:0] OP_B    = 6'h14;
    localparam logic [5:0] OP_BL   = 6'h15;
    localparam logic [5:0] OP_BEQ  = 6'h16;
    localparam logic [5:0] OP_BNE  = 6'h17;
    localparam logic [4:0] F_ADD = 5'h00, F_SUB = 5'h02, F_SLT = 5'h04, F_SLTU = 5'h05;
    localparam logic [4:0] F_NOR = 5'h08, F_AND = 5'h09, F_OR = 5'h0a, F_XOR = 5'h0b;
    localparam logic [4:0] F_SLLI = 5'h01, F_SRLI = 5'h09, F_SRAI = 5'h11;

    logic              clk = 1'b0;
    logic              reset = 1'b1;
    logic [XLEN-1:0]   inst_sram_addr;
    logic [XLEN-1:0]   inst_sram_rdata;
    logic              data_sram_we;
    logic [XLEN-1:0]   data_sram_addr;
    logic [XLEN-1:0]   data_sram_wdata;
    logic [XLEN-1:0]   data_sram_rdata;
    logic [XLEN-1:0]   debug_wb_pc;
    logic [3:0]        debug_wb_rf_we;
    logic [REG_AW-1:0] debug_wb_rf_wnum;
    logic [XLEN-1:0]   debug_wb_rf_wdata;

    logic [XLEN-1:0] prog [$];
    wb_trace_t       exp_q [$];
    wb_trace_t       ev_q [$];
    int              ev_cycle [$];
    int              cycles = 0;
    int              since_reset = 0;
    string           test_name = "";

    always #2 clk = ~clk;

    mc_cpu_top #(.RESET_PC(RESET_PC)) dut_i (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    sram_model #(.AW(8)) imem_i (
        .clk   (clk),
        .we    (1'b0),
        .addr  (inst_sram_addr),
        .wdata ('0),
        .rdata (inst_sram_rdata)
    );

    sram_model #(.AW(10)) dmem_i (
        .clk   (clk),
        .we    (data_sram_we),
        .addr  (data_sram_addr),
        .wdata (data_sram_wdata),
        .rdata (data_sram_rdata)
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic compare_we(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch %s: expected write enable %h, actual %h",
                                      name, exp, act));
        end
    endtask

    // write-back events are counted in cycles from the release of reset.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("timeout: run did not end within %0d cycles",
                                      TIMEOUT_CYCLES));
        end else if (reset) begin
            since_reset = 0;
        end else begin
            since_reset = since_reset + 1;
            if (debug_wb_rf_we != 4'h0) begin
                compare_we(test_name, 4'hf, debug_wb_rf_we);
                ev_q.push_back({debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata});
                ev_cycle.push_back(since_reset);
            end
        end
    end

    task automatic compare_trace(input string name, input wb_trace_t exp, input wb_trace_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch %s: expected pc=%h r%0d=%h, actual pc=%h r%0d=%h",
                name, exp.pc, exp.rf_wnum, exp.rf_wdata, act.pc, act.rf_wnum, act.rf_wdata));
        end
    endtask

    task automatic compare_word(input string name, input logic [XLEN-1:0] exp,
                                input logic [XLEN-1:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    function automatic logic [XLEN-1:0] enc_3r(input logic [4:0] fn, rd, rj, rk);
        return {12'h001, fn, rk, rj, rd};
    endfunction

    function automatic logic [XLEN-1:0] enc_shift(input logic [4:0] fn, rd, rj, ui5);
        return {12'h004, fn, ui5, rj, rd};
    endfunction

    function automatic logic [XLEN-1:0] enc_2ri12(input logic [9:0] op, input logic [4:0] rd,
                                                  input logic [4:0] rj, input logic [11:0] si12);
        return {op, si12, rj, rd};
    endfunction

    function automatic logic [XLEN-1:0] enc_addi(input logic [4:0] rd, rj,
                                                 input logic [11:0] si12);
        return enc_2ri12(OP_ADDI, rd, rj, si12);
    endfunction

    function automatic logic [XLEN-1:0] enc_2ri16(input logic [5:0] op, input logic [4:0] rd,
                                                  input logic [4:0] rj, input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [XLEN-1:0] enc_i26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};    // high offset bits go in the low field.
    endfunction

    function automatic logic [XLEN-1:0] enc_lu12i(input logic [4:0] rd, input logic [19:0] si20);
        return {7'b0001010, si20, rd};
    endfunction

    function automatic logic [XLEN-1:0] pc_at(input int idx);
        return RESET_PC + 4 * idx;
    endfunction

    task automatic start_test();
        prog.delete();
        exp_q.delete();
    endtask

    task automatic emit(input logic [XLEN-1:0] inst);
        prog.push_back(inst);
    endtask

    task automatic expect_at(input int idx, input logic [4:0] rd, input logic [XLEN-1:0] val);
        exp_q.push_back({pc_at(idx), rd, val});
    endtask

    task automatic emit_wb(input logic [XLEN-1:0] inst, input logic [4:0] rd,
                           input logic [XLEN-1:0] val);
        expect_at(prog.size(), rd, val);
        emit(inst);
    endtask

    // lu12i.w plus addi.w, with the upper part rounded for the sign of si12.
    task automatic load_const(input logic [4:0] rd, input logic [XLEN-1:0] val);
        logic [XLEN-1:0] rounded;
        rounded = val + 32'h800;
        emit_wb(enc_lu12i(rd, rounded[31:12]), rd, {rounded[31:12], 12'b0});
        emit_wb(enc_addi(rd, rd, val[11:0]), rd, val);
    endtask

    task automatic run_program(input string name, input bit check_start);
        logic [XLEN-1:0] halt_pc;
        halt_pc = pc_at(prog.size());
        test_name = name;
        prog.push_back(enc_i26(OP_B, 26'd0));
        @(posedge clk);
        reset <= 1'b1;
        foreach (prog[i]) begin
            imem_i.write_word(pc_at(i), prog[i]);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        ev_q.delete();
        ev_cycle.delete();
        reset <= 1'b0;
        @(negedge clk);
        while (inst_sram_addr != halt_pc) begin
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);
        if (ev_q.size() < exp_q.size()) begin
            stop_with_error($sformatf("%s: missing write-back events, expected %0d but saw %0d",
                                      name, exp_q.size(), ev_q.size()));
        end else if (ev_q.size() > exp_q.size()) begin
            stop_with_error($sformatf("%s: extra write-back events, expected %0d but saw %0d",
                                      name, exp_q.size(), ev_q.size()));
        end else begin
            foreach (exp_q[i]) begin
                compare_trace(name, exp_q[i], ev_q[i]);
            end
            if (check_start) begin
                compare_word(name, FIRST_WB_CYCLE, ev_cycle[0]);
            end
        end
    endtask

    task automatic test_reg_ops();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        start_test();
        a = $urandom();
        b = $urandom();
        load_const(4, a);
        load_const(5, b);
        emit_wb(enc_3r(F_ADD, 6, 4, 5), 6, a + b);
        emit_wb(enc_3r(F_SUB, 7, 4, 5), 7, a - b);
        emit_wb(enc_3r(F_SLT, 8, 4, 5), 8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        emit_wb(enc_3r(F_SLTU, 9, 4, 5), 9, (a < b) ? 32'd1 : 32'd0);
        emit_wb(enc_3r(F_NOR, 10, 4, 5), 10, ~(a | b));
        emit_wb(enc_3r(F_AND, 11, 4, 5), 11, a & b);
        emit_wb(enc_3r(F_OR, 12, 4, 5), 12, a | b);
        emit_wb(enc_3r(F_XOR, 13, 4, 5), 13, a ^ b);
        run_program("reg_ops", 1'b0);
    endtask

    task automatic test_imm_shifts();
        logic [XLEN-1:0] v;
        logic [19:0]     u;
        int              sh [3];
        start_test();
        v = $urandom() | 32'h8000_0000;
        u = $urandom();
        sh = '{0, 1, 31};
        load_const(4, v);
        emit_wb(enc_addi(5, 4, -5), 5, v - 32'd5);
        emit_wb(enc_lu12i(6, u), 6, {u, 12'b0});
        foreach (sh[i]) begin
            emit_wb(enc_shift(F_SLLI, 7 + 3 * i, 4, sh[i]), 7 + 3 * i, v << sh[i]);
            emit_wb(enc_shift(F_SRLI, 8 + 3 * i, 4, sh[i]), 8 + 3 * i, v >> sh[i]);
            emit_wb(enc_shift(F_SRAI, 9 + 3 * i, 4, sh[i]), 9 + 3 * i,
                    (v >> sh[i]) | ~(32'hffff_ffff >> sh[i]));    // v is negative.
        end
        run_program("imm_shifts", 1'b0);
    endtask

    task automatic test_memory();
        logic [XLEN-1:0] w [3];
        start_test();
        dmem_i.fill();
        foreach (w[i]) begin
            w[i] = $urandom();
        end
        load_const(4, 32'h0000_0100);
        foreach (w[i]) begin
            load_const(5 + i, w[i]);
        end
        emit(enc_2ri12(OP_ST, 5, 4, 0));
        emit(enc_2ri12(OP_ST, 6, 4, 8));
        emit(enc_2ri12(OP_ST, 7, 4, -4));
        emit_wb(enc_2ri12(OP_LD, 8, 4, -4), 8, w[2]);
        emit_wb(enc_2ri12(OP_LD, 9, 4, 0), 9, w[0]);
        emit_wb(enc_2ri12(OP_LD, 10, 4, 8), 10, w[1]);
        run_program("memory", 1'b0);
        compare_word("memory", w[0], dmem_i.read_word(32'h100));
        compare_word("memory", w[1], dmem_i.read_word(32'h108));
        compare_word("memory", w[2], dmem_i.read_word(32'h0fc));
    endtask

    task automatic test_branches();
        start_test();
        emit_wb(enc_addi(4, 0, 3), 4, 3);
        emit_wb(enc_addi(5, 0, 3), 5, 3);
        emit_wb(enc_addi(6, 0, 7), 6, 7);
        emit_wb(enc_addi(10, 0, 0), 10, 0);
        emit(enc_2ri16(OP_BEQ, 5, 4, 3));      // index 4 jumps forward to 7.
        emit(enc_addi(7, 0, 1));
        emit(enc_addi(7, 0, 2));
        emit(enc_2ri16(OP_BEQ, 6, 4, 2));      // 3 against 7, so it falls through.
        emit_wb(enc_addi(8, 0, 8), 8, 8);
        emit(enc_addi(10, 10, 1));
        emit(enc_2ri16(OP_BNE, 4, 10, -1));    // loops back to 9 until r10 reaches 3.
        for (int k = 1; k <= 3; k++) begin
            expect_at(9, 10, k);
        end
        emit(enc_2ri16(OP_BNE, 6, 4, 2));
        emit(enc_addi(9, 0, 9));
        emit_wb(enc_addi(11, 0, 11), 11, 11);
        emit(enc_i26(OP_B, 3));
        emit(enc_addi(12, 0, 12));
        emit(enc_i26(OP_B, 3));
        emit(enc_2ri16(OP_BEQ, 5, 4, -2));     // backward to 15.
        emit(enc_addi(13, 0, 13));
        expect_at(15, 12, 12);
        run_program("branches", 1'b0);
    endtask

    task automatic test_calls();
        start_test();
        emit_wb(enc_addi(4, 0, 12'h055), 4, 32'h55);
        emit(enc_i26(OP_BL, 4));
        emit(enc_addi(6, 0, 6));
        emit(enc_addi(8, 0, 8));
        emit(enc_i26(OP_B, 3));
        emit(enc_addi(5, 4, 1));
        emit(enc_2ri16(OP_JIRL, 2, 1, 1));     // returns one word past the link address.
        expect_at(1, 1, pc_at(1) + 4);
        expect_at(5, 5, 32'h56);
        expect_at(6, 2, pc_at(6) + 4);
        expect_at(3, 8, 8);
        run_program("calls", 1'b0);
    endtask

    task automatic test_reset_r0();
        start_test();
        emit_wb(enc_addi(4, 0, 9), 4, 9);
        emit_wb(enc_3r(F_ADD, 0, 4, 4), 0, 18);
        emit_wb(enc_3r(F_ADD, 5, 0, 4), 5, 9);
        run_program("reset_r0", 1'b1);
    endtask

    initial begin
        void'($urandom(6));
        test_reg_ops();
        test_imm_shifts();
        test_memory();
        test_branches();
        test_calls();
        test_reset_r0();
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- sim/sram_model.sv
`timescale 1ns/1ps

module sram_model #(
    parameter int AW = 10
) (
    input  logic                        clk,
    input  logic                        we,
    input  logic [mc_cpu_pkg::XLEN-1:0] addr,
    input  logic [mc_cpu_pkg::XLEN-1:0] wdata,
    output logic [mc_cpu_pkg::XLEN-1:0] rdata
);
    import mc_cpu_pkg::*;

    logic [XLEN-1:0] mem [2**AW];

    always @(posedge clk) begin
        if (we) begin
            mem[addr[AW+1:2]] <= wdata;
        end
        rdata <= mem[addr[AW+1:2]];    // read data shows up one cycle after the address.
    end

    task automatic fill();
        logic [XLEN-1:0] word_addr;
        for (int i = 0; i < 2**AW; i++) begin
            word_addr = i * 4;
            mem[i] = word_addr ^ 32'h5a5a_c3c3;
        end
    endtask

    task automatic write_word(input logic [XLEN-1:0] waddr, input logic [XLEN-1:0] data);
        mem[waddr[AW+1:2]] = data;
    endtask

    function automatic logic [XLEN-1:0] read_word(input logic [XLEN-1:0] raddr);
        return mem[raddr[AW+1:2]];
    endfunction

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
    input  mc_cpu_pkg::alu_op_e         alu_op,
    input  logic [mc_cpu_pkg::XLEN-1:0] src1,
    input  logic [mc_cpu_pkg::XLEN-1:0] src2,
    output logic [mc_cpu_pkg::XLEN-1:0] result
);
    import mc_cpu_pkg::*;

    logic [4:0]      shamt;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;

    assign shamt = src2[4:0];
    assign sum   = src1 + src2;
    assign diff  = src1 - src2;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = sum;
            ALU_SUB:  result = diff;
            ALU_SLT:  result = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {31'b0, src1 < src2};
            ALU_AND:  result = src1 & src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(src1) >>> shamt);
            ALU_LUI:  result = src2;    // the decoder has already shifted si20.
            default:  result = sum;
        endcase
    end

endmodule

//--- src/cpu_ctrl.sv
`timescale 1ns/1ps

module cpu_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  mc_cpu_pkg::decoded_inst_t dec,
    output mc_cpu_pkg::cpu_state_e    state
);
    import mc_cpu_pkg::*;

    cpu_state_e next_state;
    logic       load_q;
    logic       store_q;
    logic       is_jump_only;

    // these branches finish in decode because they write no register.
    assign is_jump_only = (dec.br_kind == BR_B) ||
                          (dec.br_kind == BR_BEQ) ||
                          (dec.br_kind == BR_BNE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    // the instruction word is gone after decode, so keep the memory bits here.
    always_ff @(posedge clk) begin
        if (reset) begin
            load_q  <= 1'b0;
            store_q <= 1'b0;
        end else if (state == DECODE) begin
            load_q  <= dec.is_load;
            store_q <= dec.is_store;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            FETCH: begin
                next_state = DECODE;
            end
            DECODE: begin
                if (is_jump_only) begin
                    next_state = FETCH;
                end else begin
                    next_state = EXEC;
                end
            end
            EXEC: begin
                if (load_q || store_q) begin
                    next_state = MEM;
                end else begin
                    next_state = WB;
                end
            end
            MEM: begin
                if (load_q) begin
                    next_state = WB;    // load data shows up one cycle later.
                end else begin
                    next_state = FETCH;
                end
            end
            WB: begin
                next_state = FETCH;
            end
            default: begin
                next_state = FETCH;
            end
        endcase
    end

endmodule

//--- src/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  mc_cpu_pkg::cpu_state_e        state,
    input  mc_cpu_pkg::decoded_inst_t     dec,
    input  logic [mc_cpu_pkg::XLEN-1:0]   rj_value,
    input  logic [mc_cpu_pkg::XLEN-1:0]   rkd_value,
    input  logic [mc_cpu_pkg::XLEN-1:0]   inst_pc,
    input  logic [mc_cpu_pkg::XLEN-1:0]   data_sram_rdata,
    output logic                          data_sram_we,
    output logic [mc_cpu_pkg::XLEN-1:0]   data_sram_addr,
    output logic [mc_cpu_pkg::XLEN-1:0]   data_sram_wdata,
    output logic                          rf_we,
    output logic [mc_cpu_pkg::REG_AW-1:0] rf_waddr,
    output logic [mc_cpu_pkg::XLEN-1:0]   rf_wdata,
    output mc_cpu_pkg::wb_trace_t         trace
);
    import mc_cpu_pkg::*;

    decoded_inst_t   dec_q;
    logic [XLEN-1:0] rj_q;
    logic [XLEN-1:0] rkd_q;
    logic [XLEN-1:0] alu_src1;
    logic [XLEN-1:0] alu_src2;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] result_q;

    // the decoded fields must outlive the instruction SRAM output.
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_q <= '0;
        end else if (state == DECODE) begin
            dec_q <= dec;
        end
    end

    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            rj_q  <= rj_value;
            rkd_q <= rkd_value;
        end
    end

    assign alu_src1 = dec_q.src1_is_pc ? inst_pc : rj_q;
    assign alu_src2 = dec_q.src2_is_imm ? dec_q.imm : rkd_q;

    alu alu_i (
        .alu_op (dec_q.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    always_ff @(posedge clk) begin
        if (state == EXEC) begin
            result_q <= alu_result;
        end
    end

    assign data_sram_we    = (state == MEM) && dec_q.is_store;
    assign data_sram_addr  = result_q;    // held through WB so the load data lines up.
    assign data_sram_wdata = rkd_q;

    assign rf_we    = (state == WB) && dec_q.gr_we;
    assign rf_waddr = dec_q.dest;
    assign rf_wdata = dec_q.is_load ? data_sram_rdata : result_q;

    assign trace.pc       = inst_pc;
    assign trace.rf_wnum  = rf_waddr;
    assign trace.rf_wdata = rf_wdata;

endmodule

//--- src/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  logic [mc_cpu_pkg::XLEN-1:0] inst,
    output mc_cpu_pkg::decoded_inst_t   dec
);
    import mc_cpu_pkg::*;

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        is_3r;
    logic        is_shift;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic        inst_b, inst_bl, inst_beq, inst_bne, inst_jirl;
    logic        known;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    assign i26      = {inst[9:0], inst[25:10]};  // offs[25:16] sits in the low bits.

    assign is_3r    = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign is_shift = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = is_3r && (op_19_15 == 5'h00);
    assign inst_sub_w   = is_3r && (op_19_15 == 5'h02);
    assign inst_slt     = is_3r && (op_19_15 == 5'h04);
    assign inst_sltu    = is_3r && (op_19_15 == 5'h05);
    assign inst_nor     = is_3r && (op_19_15 == 5'h08);
    assign inst_and     = is_3r && (op_19_15 == 5'h09);
    assign inst_or      = is_3r && (op_19_15 == 5'h0a);
    assign inst_xor     = is_3r && (op_19_15 == 5'h0b);
    assign inst_slli_w  = is_shift && (op_19_15 == 5'h01);
    assign inst_srli_w  = is_shift && (op_19_15 == 5'h09);
    assign inst_srai_w  = is_shift && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !inst[25];
    assign inst_ld_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign inst_st_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign inst_jirl    = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_bl      = (op_31_26 == 6'h15);
    assign inst_beq     = (op_31_26 == 6'h16);
    assign inst_bne     = (op_31_26 == 6'h17);

    assign known = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and |
                   inst_or | inst_xor | inst_slli_w | inst_srli_w | inst_srai_w |
                   inst_addi_w | inst_lu12i_w | inst_ld_w | inst_st_w |
                   inst_b | inst_bl | inst_beq | inst_bne | inst_jirl;

    always_comb begin
        dec = '0;
        dec.alu_op = ALU_ADD;    // also the address and link adder.
        case (1'b1)
            inst_sub_w:   dec.alu_op = ALU_SUB;
            inst_slt:     dec.alu_op = ALU_SLT;
            inst_sltu:    dec.alu_op = ALU_SLTU;
            inst_and:     dec.alu_op = ALU_AND;
            inst_nor:     dec.alu_op = ALU_NOR;
            inst_or:      dec.alu_op = ALU_OR;
            inst_xor:     dec.alu_op = ALU_XOR;
            inst_slli_w:  dec.alu_op = ALU_SLL;
            inst_srli_w:  dec.alu_op = ALU_SRL;
            inst_srai_w:  dec.alu_op = ALU_SRA;
            inst_lu12i_w: dec.alu_op = ALU_LUI;
            default:      dec.alu_op = ALU_ADD;
        endcase

        dec.br_kind = BR_NONE;
        case (1'b1)
            inst_b:    dec.br_kind = BR_B;
            inst_bl:   dec.br_kind = BR_BL;
            inst_beq:  dec.br_kind = BR_BEQ;
            inst_bne:  dec.br_kind = BR_BNE;
            inst_jirl: dec.br_kind = BR_JIRL;
            default:   dec.br_kind = BR_NONE;
        endcase

        dec.src1_is_pc  = inst_bl | inst_jirl;
        dec.src2_is_imm = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w |
                          inst_lu12i_w | inst_ld_w | inst_st_w | inst_bl | inst_jirl;
        dec.is_load     = inst_ld_w;
        dec.is_store    = inst_st_w;
        dec.gr_we       = known & ~(inst_st_w | inst_b | inst_beq | inst_bne);
        dec.dest        = inst_bl ? 5'd1 : rd;
        dec.rf_raddr1   = rj;
        dec.rf_raddr2   = (inst_beq | inst_bne | inst_st_w) ? rd : rk;

        if (inst_bl || inst_jirl) begin
            dec.imm = 32'd4;
        end else if (inst_lu12i_w) begin
            dec.imm = {i20, 12'b0};
        end else if (inst_slli_w || inst_srli_w || inst_srai_w) begin
            dec.imm = {27'b0, rk};    // ui5 shares the rk field.
        end else begin
            dec.imm = {{20{i12[11]}}, i12};
        end

        if (inst_b || inst_bl) begin
            dec.br_offs = {{4{i26[25]}}, i26, 2'b0};
        end else begin
            dec.br_offs = {{14{i16[15]}}, i16, 2'b0};
        end
    end

endmodule

//--- src/mc_cpu_pkg.sv
package mc_cpu_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXEC,
        MEM,
        WB
    } cpu_state_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_B,
        BR_BL,
        BR_BEQ,
        BR_BNE,
        BR_JIRL
    } br_kind_e;

    typedef struct packed {
        alu_op_e             alu_op;
        br_kind_e            br_kind;
        logic                src1_is_pc;    // link value uses pc as the first operand.
        logic                src2_is_imm;
        logic                is_load;
        logic                is_store;
        logic                gr_we;
        logic [REG_AW-1:0]   dest;
        logic [REG_AW-1:0]   rf_raddr1;
        logic [REG_AW-1:0]   rf_raddr2;
        logic [XLEN-1:0]     imm;
        logic [XLEN-1:0]     br_offs;
    } decoded_inst_t;

    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [REG_AW-1:0]   rf_wnum;
        logic [XLEN-1:0]     rf_wdata;
    } wb_trace_t;

endpackage

//--- src/mc_cpu_top.sv
`timescale 1ns/1ps

module mc_cpu_top #(
    parameter logic [mc_cpu_pkg::XLEN-1:0] RESET_PC = 32'h1c00_0000
) (
    input  logic                          clk,
    input  logic                          reset,
    output logic [mc_cpu_pkg::XLEN-1:0]   inst_sram_addr,
    input  logic [mc_cpu_pkg::XLEN-1:0]   inst_sram_rdata,
    output logic                          data_sram_we,
    output logic [mc_cpu_pkg::XLEN-1:0]   data_sram_addr,
    output logic [mc_cpu_pkg::XLEN-1:0]   data_sram_wdata,
    input  logic [mc_cpu_pkg::XLEN-1:0]   data_sram_rdata,
    output logic [mc_cpu_pkg::XLEN-1:0]   debug_wb_pc,
    output logic [3:0]                    debug_wb_rf_we,
    output logic [mc_cpu_pkg::REG_AW-1:0] debug_wb_rf_wnum,
    output logic [mc_cpu_pkg::XLEN-1:0]   debug_wb_rf_wdata
);
    import mc_cpu_pkg::*;

    cpu_state_e      state;
    decoded_inst_t   dec;
    wb_trace_t       trace;
    logic [XLEN-1:0] rj_value;
    logic [XLEN-1:0] rkd_value;
    logic [XLEN-1:0] inst_pc;
    logic            rf_we;
    logic [REG_AW-1:0] rf_waddr;
    logic [XLEN-1:0] rf_wdata;

    cpu_ctrl cpu_ctrl_i (
        .clk   (clk),
        .reset (reset),
        .dec   (dec),
        .state (state)
    );

    inst_decode inst_decode_i (
        .inst (inst_sram_rdata),
        .dec  (dec)
    );

    regfile regfile_i (
        .clk    (clk),
        .raddr1 (dec.rf_raddr1),
        .raddr2 (dec.rf_raddr2),
        .rdata1 (rj_value),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) pc_unit_i (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .dec       (dec),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .pc        (inst_sram_addr),    // the fetch address is the pc itself.
        .inst_pc   (inst_pc)
    );

    exec_stage exec_stage_i (
        .clk             (clk),
        .reset           (reset),
        .state           (state),
        .dec             (dec),
        .rj_value        (rj_value),
        .rkd_value       (rkd_value),
        .inst_pc         (inst_pc),
        .data_sram_rdata (data_sram_rdata),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata),
        .trace           (trace)
    );

    assign debug_wb_pc       = trace.pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = trace.rf_wnum;
    assign debug_wb_rf_wdata = trace.rf_wdata;

endmodule

//--- src/pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
    parameter logic [mc_cpu_pkg::XLEN-1:0] RESET_PC = 32'h1c00_0000
) (
    input  logic                        clk,
    input  logic                        reset,
    input  mc_cpu_pkg::cpu_state_e      state,
    input  mc_cpu_pkg::decoded_inst_t   dec,
    input  logic [mc_cpu_pkg::XLEN-1:0] rj_value,
    input  logic [mc_cpu_pkg::XLEN-1:0] rkd_value,
    output logic [mc_cpu_pkg::XLEN-1:0] pc,
    output logic [mc_cpu_pkg::XLEN-1:0] inst_pc
);
    import mc_cpu_pkg::*;

    logic            br_taken;
    logic [XLEN-1:0] br_target;

    always_comb begin
        case (dec.br_kind)
            BR_B, BR_BL, BR_JIRL: br_taken = 1'b1;
            BR_BEQ:               br_taken = (rj_value == rkd_value);
            BR_BNE:               br_taken = (rj_value != rkd_value);
            default:              br_taken = 1'b0;
        endcase
    end

    assign br_target = (dec.br_kind == BR_JIRL) ? rj_value + dec.br_offs
                                                : inst_pc + dec.br_offs;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= RESET_PC;
            inst_pc <= RESET_PC;
        end else begin
            if (state == FETCH) begin
                inst_pc <= pc;    // held for the trace until the next fetch.
            end
            if (state == DECODE) begin
                pc <= br_taken ? br_target : inst_pc + 32'd4;
            end
        end
    end

endmodule

//--- src/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                          clk,
    input  logic [mc_cpu_pkg::REG_AW-1:0] raddr1,
    input  logic [mc_cpu_pkg::REG_AW-1:0] raddr2,
    output logic [mc_cpu_pkg::XLEN-1:0]   rdata1,
    output logic [mc_cpu_pkg::XLEN-1:0]   rdata2,
    input  logic                          we,
    input  logic [mc_cpu_pkg::REG_AW-1:0] waddr,
    input  logic [mc_cpu_pkg::XLEN-1:0]   wdata
);
    import mc_cpu_pkg::*;

    logic [XLEN-1:0] rf [2**REG_AW];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 reads as zero whatever the array holds.
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule
